// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= copper_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim.f ====
src/copper_pkg.sv
src/copper_mem.sv
src/raster_timing.sv
src/copper_fetch.sv
src/copper_exec.sv
src/copper_top.sv
verif/copper_tb.sv

// ==== src/copper_exec.sv ====
// copper_exec: instruction decode, WAIT compare, MOVE register write and END halt
`timescale 1ns/1ps

module copper_exec (
    input  logic                   clk,
    input  logic                   rst_i,
    input  copper_pkg::cop_fetch_t fetch_i,
    input  copper_pkg::raster_t    pos_i,
    input  logic                   frame_start_i,
    output logic                   stall_o,
    output logic                   reg_wr_o,
    output copper_pkg::reg_wr_t    reg_o
);
    import copper_pkg::*;

    logic      halted_q;
    cop_wait_t wait_view;
    cop_move_t move_view;
    logic      live;
    logic      is_wait;
    logic      is_move;
    logic      is_end;
    logic      reached;
    logic      retire_move;

    always_comb begin
        wait_view = fetch_i.instr.wait_s;
        move_view = fetch_i.instr.move_s;

        // nothing executes once halted
        live    = fetch_i.valid && !halted_q;
        is_wait = live && (wait_view.opcode == op_wait);
        is_move = live && (move_view.opcode == op_move);
        // unknown opcodes halt like END
        is_end  = live && !is_wait && !is_move;

        // line first, then pixel within the target line
        reached = (pos_i.v > wait_view.v_pos) ||
                  ((pos_i.v == wait_view.v_pos) && (pos_i.h >= wait_view.h_pos));

        retire_move = is_move && !frame_start_i;
    end

    assign stall_o = halted_q || is_end || (is_wait && !reached);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            halted_q <= 1'b0;
        end else if (frame_start_i) begin
            halted_q <= 1'b0;
        end else if (is_end) begin
            halted_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            reg_wr_o <= 1'b0;
        end else begin
            reg_wr_o <= retire_move;
        end
    end

    // write payload only changes alongside a strobe
    always_ff @(posedge clk) begin
        if (retire_move) begin
            reg_o.addr <= move_view.reg_addr;
            reg_o.data <= move_view.data;
        end
    end

endmodule

// ==== src/copper_fetch.sv ====
// copper_fetch: program counter, memory read address and fetched instruction
`timescale 1ns/1ps

module copper_fetch (
    input  logic                          clk,
    input  logic                          rst_i,
    input  logic                          en_i,
    input  logic                          frame_start_i,
    input  logic                          stall_i,
    output logic [copper_pkg::cop_aw-1:0] rd_addr_o,
    input  copper_pkg::word_t             even_i,
    input  copper_pkg::word_t             odd_i,
    output copper_pkg::cop_fetch_t        fetch_o
);
    import copper_pkg::*;

    // pc_q is the next address to read, rd_pc_q the one now at the memory output
    logic [cop_aw-1:0] pc_q;
    logic [cop_aw-1:0] rd_pc_q;
    logic              valid_q;
    logic              run_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q    <= '0;
            rd_pc_q <= '0;
            valid_q <= 1'b0;
            run_q   <= 1'b0;
        end else if (!en_i) begin
            pc_q    <= '0;
            valid_q <= 1'b0;
            run_q   <= 1'b0;
        end else if (frame_start_i) begin
            // restart the program from address zero
            pc_q    <= '0;
            valid_q <= 1'b0;
            run_q   <= 1'b1;
        end else if (run_q && !stall_i) begin
            rd_pc_q <= pc_q;
            pc_q    <= pc_q + 1'b1;
            valid_q <= 1'b1;
        end
    end

    // re-read the held word while stalled so the memory output stays put
    assign rd_addr_o = stall_i ? rd_pc_q : pc_q;

    always_comb begin
        fetch_o.valid = valid_q;
        fetch_o.pc    = rd_pc_q;
        fetch_o.instr = cop_instr_u'({even_i, odd_i});
    end

endmodule

// ==== src/copper_mem.sv ====
// copper_mem: one 16-bit half of the copper program memory
`timescale 1ns/1ps

module copper_mem #(
    parameter bit odd_word = 1'b0
) (
    input  logic                         clk,
    input  logic                         wr_en_i,
    input  logic [copper_pkg::cop_aw-1:0] wr_addr_i,
    input  copper_pkg::word_t            wr_data_i,
    input  logic [copper_pkg::cop_aw-1:0] rd_addr_i,
    output copper_pkg::word_t            rd_data_o
);
    import copper_pkg::*;

    localparam int depth = 2 ** cop_aw;

    // even half carries the opcode, so an END there makes every slot halt
    localparam word_t fill_word = odd_word ? 16'h0000 : {op_end, 12'h000};

    word_t mem [depth];

    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = fill_word;
        end
    end

    // host write port
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // registered read, data valid one cycle after the address
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

// ==== src/copper_pkg.sv ====
// copper package: raster and memory sizes, opcodes, instruction union, pipeline structs
package copper_pkg;

    // raster geometry, kept tiny for fast simulation
    localparam int h_total  = 64;
    localparam int v_total  = 24;
    localparam int raster_w = 10;

    // program memory holds 256 instructions of 32 bits
    localparam int cop_aw = 8;
    localparam int reg_aw = 12;

    // opcode lives in the top nibble of every instruction
    localparam logic [3:0] op_wait = 4'd0;
    localparam logic [3:0] op_move = 4'd1;
    localparam logic [3:0] op_end  = 4'd3;

    typedef logic [15:0] word_t;

    // wait view: raster target
    typedef struct packed {
        logic [3:0]          opcode;
        logic [1:0]          rsvd_hi;
        logic [raster_w-1:0] v_pos;
        logic [5:0]          rsvd_lo;
        logic [raster_w-1:0] h_pos;
    } cop_wait_t;

    // move view: register address and value
    typedef struct packed {
        logic [3:0]        opcode;
        logic [reg_aw-1:0] reg_addr;
        word_t             data;
    } cop_move_t;

    // bits 31..16 come from the even half, 15..0 from the odd half
    typedef union packed {
        cop_wait_t wait_s;
        cop_move_t move_s;
    } cop_instr_u;

    typedef struct packed {
        logic              valid;
        logic [cop_aw-1:0] pc;
        cop_instr_u        instr;
    } cop_fetch_t;

    typedef struct packed {
        logic [raster_w-1:0] h;
        logic [raster_w-1:0] v;
    } raster_t;

    typedef struct packed {
        logic [reg_aw-1:0] addr;
        word_t             data;
    } reg_wr_t;

endpackage

// ==== src/copper_top.sv ====
// copper_top: program memory halves, raster counter, fetch and execute stages
`timescale 1ns/1ps

module copper_top (
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic                        cop_en_i,
    input  logic                        host_wr_i,
    input  logic [copper_pkg::cop_aw:0] host_addr_i,
    input  copper_pkg::word_t           host_data_i,
    output copper_pkg::raster_t         raster_o,
    output logic                        reg_wr_o,
    output copper_pkg::reg_wr_t         reg_o
);
    import copper_pkg::*;

    logic              odd_sel;
    logic [cop_aw-1:0] host_waddr;
    logic              even_wr;
    logic              odd_wr;
    logic [cop_aw-1:0] rd_addr;
    word_t             even_data;
    word_t             odd_data;
    logic              frame_start;
    logic              stall;
    cop_fetch_t        fetch;

    // host word address: bit 0 picks the half, the rest is the instruction
    assign odd_sel    = host_addr_i[0];
    assign host_waddr = host_addr_i[cop_aw:1];
    assign even_wr    = host_wr_i && !odd_sel;
    assign odd_wr     = host_wr_i && odd_sel;

    copper_mem #(.odd_word(1'b0)) u_mem_even (
        .clk       (clk),
        .wr_en_i   (even_wr),
        .wr_addr_i (host_waddr),
        .wr_data_i (host_data_i),
        .rd_addr_i (rd_addr),
        .rd_data_o (even_data)
    );

    copper_mem #(.odd_word(1'b1)) u_mem_odd (
        .clk       (clk),
        .wr_en_i   (odd_wr),
        .wr_addr_i (host_waddr),
        .wr_data_i (host_data_i),
        .rd_addr_i (rd_addr),
        .rd_data_o (odd_data)
    );

    raster_timing u_raster (
        .clk           (clk),
        .rst_i         (rst_i),
        .pos_o         (raster_o),
        .frame_start_o (frame_start)
    );

    copper_fetch u_fetch (
        .clk           (clk),
        .rst_i         (rst_i),
        .en_i          (cop_en_i),
        .frame_start_i (frame_start),
        .stall_i       (stall),
        .rd_addr_o     (rd_addr),
        .even_i        (even_data),
        .odd_i         (odd_data),
        .fetch_o       (fetch)
    );

    copper_exec u_exec (
        .clk           (clk),
        .rst_i         (rst_i),
        .fetch_i       (fetch),
        .pos_i         (raster_o),
        .frame_start_i (frame_start),
        .stall_o       (stall),
        .reg_wr_o      (reg_wr_o),
        .reg_o         (reg_o)
    );

endmodule

// ==== src/raster_timing.sv ====
// raster_timing: horizontal and vertical beam counters with frame start pulse
`timescale 1ns/1ps

module raster_timing (
    input  logic                clk,
    input  logic                rst_i,
    output copper_pkg::raster_t pos_o,
    output logic                frame_start_o
);
    import copper_pkg::*;

    localparam logic [raster_w-1:0] h_last = raster_w'(h_total - 1);
    localparam logic [raster_w-1:0] v_last = raster_w'(v_total - 1);

    logic [raster_w-1:0] h_q;
    logic [raster_w-1:0] v_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            h_q <= '0;
            v_q <= '0;
        end else if (h_q == h_last) begin
            h_q <= '0;
            // end of line, step to the next one or wrap the frame
            if (v_q == v_last) begin
                v_q <= '0;
            end else begin
                v_q <= v_q + 1'b1;
            end
        end else begin
            h_q <= h_q + 1'b1;
        end
    end

    always_comb begin
        pos_o.h = h_q;
        pos_o.v = v_q;
    end

    // high for exactly the one cycle spent at (0,0)
    assign frame_start_o = (h_q == '0) && (v_q == '0);

endmodule

// ==== verif/copper_tb.sv ====
// copper_tb: trace driven testbench for the copper coprocessor top level
`timescale 1ns/1ps

module copper_tb;
    import copper_pkg::*;

    localparam int wait_limit = 3 * h_total * v_total;
    localparam int drive_dly  = 1;

    logic            clk = 1'b0;
    logic            rst_i;
    logic            cop_en_i;
    logic            host_wr_i;
    logic [cop_aw:0] host_addr_i;
    word_t           host_data_i;
    raster_t         raster_o;
    logic            reg_wr_o;
    reg_wr_t         reg_o;

    // program words and expected writes from the trace
    logic [cop_aw:0] prog_addr_q[$];
    word_t           prog_data_q[$];
    reg_wr_t         exp_wr_q[$];
    raster_t         exp_pos_q[$];
    int              n_frames;

    // writes seen at the DUT outputs, tagged with raster and frame number
    reg_wr_t         got_wr_q[$];
    raster_t         got_pos_q[$];
    int              got_frame_q[$];
    int              frame_cnt = 0;

    // beam position expected at the next sample
    raster_t         ref_pos;

    copper_top u_dut (
        .clk         (clk),
        .rst_i       (rst_i),
        .cop_en_i    (cop_en_i),
        .host_wr_i   (host_wr_i),
        .host_addr_i (host_addr_i),
        .host_data_i (host_data_i),
        .raster_o    (raster_o),
        .reg_wr_o    (reg_wr_o),
        .reg_o       (reg_o)
    );

    always #50 clk = ~clk;

    // sampled mid-cycle where outputs are settled
    always @(negedge clk) begin
        if (!rst_i) begin
            check_val(32'(raster_o), 32'(ref_pos), "raster position");
            ref_pos = next_position(ref_pos);
            if (raster_o.h == '0 && raster_o.v == '0) begin
                frame_cnt++;
            end
            if (reg_wr_o) begin
                got_wr_q.push_back(reg_o);
                got_pos_q.push_back(raster_o);
                got_frame_q.push_back(frame_cnt);
            end
        end else begin
            ref_pos = '0;
        end
    end

    task automatic stop_with_failure();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s, got %0h expected %0h", $time, msg, got, exp);
            stop_with_failure();
        end
    endtask

    // beam steps one pixel per clock and wraps at line and frame ends
    function automatic raster_t next_position(input raster_t pos);
        int      h;
        int      v;
        raster_t nxt;
        h = (int'(pos.h) + 1) % h_total;
        v = int'(pos.v);
        if (h == 0) begin
            v = (v + 1) % v_total;
        end
        nxt.h = raster_w'(h);
        nxt.v = raster_w'(v);
        return nxt;
    endfunction

    // line first, then pixel within the target line
    function automatic logic target_reached(input raster_t pos, input raster_t tgt);
        return (pos.v > tgt.v) || ((pos.v == tgt.v) && (pos.h >= tgt.h));
    endfunction

    task automatic load_trace();
        int               fd;
        int               r;
        logic [7:0]       kind;
        logic [31:0]      a;
        logic [31:0]      d;
        logic [31:0]      v;
        logic [31:0]      h;
        logic [8*160-1:0] rest;
        reg_wr_t          wr;
        raster_t          pos;
        bit               done;
        fd = $fopen("verif/copper_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file verif/copper_trace.txt");
            stop_with_failure();
        end else begin
            done = 1'b0;
            n_frames = 0;
            while (!done) begin
                r = $fscanf(fd, "%s", kind);
                if (r != 1) begin
                    done = 1'b1;
                end else if (kind == "#") begin
                    r = $fgets(rest, fd);
                end else if (kind == "P") begin
                    r = $fscanf(fd, "%h %h", a, d);
                    prog_addr_q.push_back(a[cop_aw:0]);
                    prog_data_q.push_back(d[15:0]);
                end else if (kind == "E") begin
                    r = $fscanf(fd, "%h %h %d %d", a, d, v, h);
                    wr.addr = a[reg_aw-1:0];
                    wr.data = d[15:0];
                    pos.v = v[raster_w-1:0];
                    pos.h = h[raster_w-1:0];
                    exp_wr_q.push_back(wr);
                    exp_pos_q.push_back(pos);
                end else if (kind == "F") begin
                    r = $fscanf(fd, "%d", n_frames);
                end else begin
                    $display("the trace file holds a line of unknown kind");
                    stop_with_failure();
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic wait_next_frame();
        int start;
        int cycles;
        start = frame_cnt;
        cycles = 0;
        while (frame_cnt == start) begin
            if (cycles == wait_limit) begin
                $display("timeout while waiting for the raster to reach (0,0)");
                stop_with_failure();
            end else begin
                @(posedge clk);
                #(drive_dly);
                cycles++;
            end
        end
    endtask

    task automatic wait_write_count(input int target);
        int cycles;
        cycles = 0;
        while (got_wr_q.size() < target) begin
            if (cycles == wait_limit) begin
                $display("timeout while waiting for register write number %0d", target);
                stop_with_failure();
            end else begin
                @(posedge clk);
                #(drive_dly);
                cycles++;
            end
        end
    endtask

    task automatic wait_line(input int line);
        int cycles;
        cycles = 0;
        while (int'(raster_o.v) != line) begin
            if (cycles == wait_limit) begin
                $display("timeout while waiting for raster line %0d", line);
                stop_with_failure();
            end else begin
                @(posedge clk);
                #(drive_dly);
                cycles++;
            end
        end
    endtask

    // compare n captured writes from base against the first n trace entries
    task automatic check_frame(input int base, input int n, input int frame);
        for (int i = 0; i < n; i++) begin
            check_val(32'(got_wr_q[base+i].addr), 32'(exp_wr_q[i].addr), "write address");
            check_val(32'(got_wr_q[base+i].data), 32'(exp_wr_q[i].data), "write data");
            check_val(got_frame_q[base+i], frame, "frame of write");
            if (exp_pos_q[i] != '0) begin
                check_val(32'(target_reached(got_pos_q[base+i], exp_pos_q[i])), 1,
                          "raster position reached the WAIT target");
            end
        end
    endtask

    initial begin
        int base;
        int frame;
        int n_exp;
        int n_pre;
        rst_i = 1'b1;
        cop_en_i = 1'b1;
        host_wr_i = 1'b0;
        host_addr_i = '0;
        host_data_i = '0;
        load_trace();
        n_exp = exp_wr_q.size();
        n_pre = 0;
        while (n_pre < n_exp && exp_pos_q[n_pre] == '0) begin
            n_pre++;
        end
        check_val(32'(n_pre > 0 && n_frames > 0), 1, "trace holds writes, frames and a WAIT");
        repeat (8) @(posedge clk);
        #(drive_dly);
        rst_i = 1'b0;

        // END filled memory gives a silent frame
        wait_next_frame();
        wait_next_frame();
        check_val(32'(got_wr_q.size()), 0, "writes from the END filled memory");

        cop_en_i = 1'b0;
        for (int i = 0; i < prog_addr_q.size(); i++) begin
            host_wr_i = 1'b1;
            host_addr_i = prog_addr_q[i];
            host_data_i = prog_data_q[i];
            @(posedge clk);
            #(drive_dly);
        end
        host_wr_i = 1'b0;
        cop_en_i = 1'b1;

        // same sequence every frame, and silence between END and the next frame
        base = 0;
        for (int f = 0; f < n_frames; f++) begin
            wait_next_frame();
            check_val(32'(got_wr_q.size()), base, "writes before the frame start");
            frame = frame_cnt;
            wait_write_count(base + n_exp);
            check_frame(base, n_exp, frame);
            base += n_exp;
        end
        wait_next_frame();
        check_val(32'(got_wr_q.size()), base, "writes after END");

        // disable while the copper sits on its first WAIT
        frame = frame_cnt;
        wait_write_count(base + n_pre);
        check_frame(base, n_pre, frame);
        cop_en_i = 1'b0;
        base += n_pre;
        wait_next_frame();
        wait_line(v_total / 2);
        check_val(32'(got_wr_q.size()), base, "writes while disabled");

        // re-enable mid-frame, program restarts at the next (0,0)
        cop_en_i = 1'b1;
        wait_next_frame();
        check_val(32'(got_wr_q.size()), base, "writes before the restart frame");
        frame = frame_cnt;
        wait_write_count(base + n_exp);
        check_frame(base, n_exp, frame);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== verif/copper_trace.txt ====
# P host_addr(hex) data(hex) : program word, host address bit 0 selects the odd half
# E reg_addr(hex) data(hex) wait_v(dec) wait_h(dec) : expected write, 0 0 without a WAIT
P 000 1100
P 001 1111
P 002 1101
P 003 2222
P 004 1102
P 005 3333
P 006 0004
P 007 000a
P 008 1180
P 009 abcd
P 00a 1181
P 00b 0042
P 00c 000c
P 00d 0028
P 00e 1200
P 00f beef
P 010 3000
P 011 0000
E 100 1111 0 0
E 101 2222 0 0
E 102 3333 0 0
E 180 abcd 4 10
E 181 0042 4 10
E 200 beef 12 40
F 3
